// ==== div_regfile.f ====
+incdir+tests
hdl/div_pkg.sv
hdl/reg_file.sv
hdl/int_div_regfile.sv
hdl/div_regfile_top.sv
tests/tb_div_regfile.sv

// ==== Makefile ====
# Verilator build of the division subsystem testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f div_regfile.f \
		--top-module tb_div_regfile -o tb_div_regfile_sim
	./obj_dir/tb_div_regfile_sim | tee /dev/stderr | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== tests/div_cases.svh ====
// fixed division cases, included inside the testbench module after dw and sw
// columns: preload a, preload b, rs_a, rs_b, quotient select, remainder select,
//          expected quotient, expected remainder, host write phase
//          (0 none, 1 during calc, 2 during write-back), host select, host data
`ifndef DIV_CASES_SVH
`define DIV_CASES_SVH

typedef struct packed {
    logic [dw-1:0] pre_a;
    logic [dw-1:0] pre_b;
    logic [sw-1:0] rs_a;
    logic [sw-1:0] rs_b;
    logic [sw-1:0] quot_sel;
    logic [sw-1:0] mod_sel;
    logic [dw-1:0] exp_quot;
    logic [dw-1:0] exp_rem;
    logic [1:0]    host_when;
    logic [sw-1:0] host_sel;
    logic [dw-1:0] host_data;
} div_case_t;

localparam int num_cases = 18;

localparam div_case_t case_table [num_cases] = '{
    '{32'd100, 32'd7, 5'd1, 5'd2, 5'd3, 5'd4, 32'd14, 32'd2, 2'd0, 5'd0, 32'h0},
    '{32'd12345, 32'd12345, 5'd5, 5'd6, 5'd7, 5'd8, 32'd1, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'd3, 32'd10, 5'd1, 5'd2, 5'd9, 5'd10, 32'd0, 32'd3, 2'd0, 5'd0, 32'h0},
    '{32'hffffffff, 32'hffffffff, 5'd1, 5'd2, 5'd3, 5'd4, 32'd1, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'hffffffff, 32'd1, 5'd1, 5'd2, 5'd3, 5'd4, 32'hffffffff, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'hffffffff, 32'd3, 5'd1, 5'd2, 5'd3, 5'd4, 32'h55555555, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'd77, 32'd0, 5'd1, 5'd2, 5'd11, 5'd12, 32'hffffffff, 32'd77, 2'd0, 5'd0, 32'h0},
    '{32'd0, 32'd0, 5'd1, 5'd2, 5'd11, 5'd12, 32'hffffffff, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'd1000, 32'd9, 5'd1, 5'd2, 5'd0, 5'd13, 32'd111, 32'd1, 2'd0, 5'd0, 32'h0},
    '{32'd1000, 32'd9, 5'd1, 5'd2, 5'd14, 5'd0, 32'd111, 32'd1, 2'd0, 5'd0, 32'h0},
    '{32'd55, 32'd5, 5'd1, 5'd2, 5'd0, 5'd0, 32'd11, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'd500, 32'd12, 5'd15, 5'd16, 5'd15, 5'd16, 32'd41, 32'd8, 2'd0, 5'd0, 32'h0},
    '{32'd9, 32'd40, 5'd17, 5'd17, 5'd3, 5'd4, 32'd1, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'd81, 32'd4, 5'd18, 5'd19, 5'd20, 5'd21, 32'd20, 32'd1, 2'd1, 5'd22, 32'hdeadbeef},
    '{32'd1234567, 32'd89, 5'd1, 5'd2, 5'd23, 5'd24, 32'd13871, 32'd48, 2'd2, 5'd23,
      32'h0a5a5a5a},
    '{32'hf0000000, 32'h10, 5'd1, 5'd2, 5'd25, 5'd26, 32'h0f000000, 32'd0, 2'd2, 5'd26,
      32'h12345678},
    '{32'd123, 32'd6, 5'd0, 5'd2, 5'd3, 5'd4, 32'd0, 32'd0, 2'd0, 5'd0, 32'h0},
    '{32'h80000001, 32'd2, 5'd1, 5'd2, 5'd3, 5'd4, 32'h40000000, 32'd1, 2'd1, 5'd3, 32'h77}
};

`endif

// ==== tests/tb_div_regfile.sv ====
// testbench for the division subsystem at default parameters
// expects 32 bit data and 32 registers, which the case table is written for
// stops with $fatal at the first wrong value
`timescale 1ns/1ps

module tb_div_regfile import div_pkg::*;;

    localparam int dw = default_data_width;
    localparam int nr = default_num_regs;
    localparam int sw = $clog2(nr);
    localparam int num_random = 200;

    `include "div_cases.svh"

    localparam int timeout_cycles = (num_cases + num_random) * (dw + 20) * 2;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    logic          div_req = 1'b0;
    logic [sw-1:0] rs_a = '0;
    logic [sw-1:0] rs_b = '0;
    logic [sw-1:0] r_quot_sel = '0;
    logic [sw-1:0] r_mod_sel = '0;
    logic          busy;
    logic          host_wr_req = 1'b0;
    logic [sw-1:0] host_wr_sel = '0;
    logic [dw-1:0] host_wr_data = '0;
    logic          host_wr_ack;
    logic [sw-1:0] obs_sel = '0;
    logic [dw-1:0] obs_data;

    logic [dw-1:0] model [nr];  // expected register contents

    div_regfile_top i_div_regfile_top (.*);

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model and checks
    function automatic logic [dw-1:0] expected_quotient(input logic [dw-1:0] a,
                                                        input logic [dw-1:0] b);
        return (b == '0) ? '1 : a / b;          // division by zero gives all ones
    endfunction

    function automatic logic [dw-1:0] expected_remainder(input logic [dw-1:0] a,
                                                         input logic [dw-1:0] b);
        return (b == '0) ? a : a % b;
    endfunction

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // every register is read back through the observation port
    task automatic check_all_regs();
        for (int i = 0; i < nr; i++) begin
            obs_sel = sw'(i);
            #1;
            assert (obs_data === model[i]) else begin
                $display("Mismatch at %0t: obs_data of r%0d got %h expected %h",
                         $time, i, obs_data, model[i]);
                stop_on_error();
            end
        end
        @(posedge clk);
        #1;
    endtask

    function automatic void set_model(input logic [sw-1:0] sel, input logic [dw-1:0] data);
        if (sel != '0) begin
            model[sel] = data;                  // r0 ignores writes
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks, each starts and ends 1 ns after a rising edge
    task automatic host_write(input logic [sw-1:0] sel, input logic [dw-1:0] data);
        host_wr_sel  = sel;
        host_wr_data = data;
        host_wr_req  = 1'b1;
        @(negedge clk);
        while (!host_wr_ack) @(negedge clk);    // may wait behind the divider
        @(posedge clk);
        #1;
        host_wr_req = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic run_case(input div_case_t c);
        host_write(c.rs_a, c.pre_a);
        set_model(c.rs_a, c.pre_a);
        host_write(c.rs_b, c.pre_b);
        set_model(c.rs_b, c.pre_b);
        rs_a       = c.rs_a;
        rs_b       = c.rs_b;
        r_quot_sel = c.quot_sel;
        r_mod_sel  = c.mod_sel;
        div_req    = 1'b1;
        @(posedge clk);
        #1;
        div_req = 1'b0;
        check_bit("busy", busy, 1'b1);
        fork
            wait_done();
            begin
                if (c.host_when == 2'd1) begin
                    repeat (3) @(posedge clk);  // inside calc
                    #1;
                    host_write(c.host_sel, c.host_data);
                end else if (c.host_when == 2'd2) begin
                    repeat (dw) @(posedge clk); // divider write request is up
                    #1;
                    host_write(c.host_sel, c.host_data);
                end
            end
        join
        @(posedge clk);
        #1;
        if (c.host_when == 2'd1) set_model(c.host_sel, c.host_data);
        set_model(c.quot_sel, c.exp_quot);
        set_model(c.mod_sel, c.exp_rem);  // remainder is written after the quotient
        if (c.host_when == 2'd2) set_model(c.host_sel, c.host_data);
        check_all_regs();
    endtask

    function automatic div_case_t make_random_case();
        div_case_t c;
        logic [dw-1:0] op_a;
        logic [dw-1:0] op_b;
        c          = '0;
        c.pre_a    = dw'($urandom);
        c.pre_b    = ($urandom % 4 == 0) ? dw'($urandom % 16) : dw'($urandom);
        c.rs_a     = sw'(1 + $urandom % (nr - 1));
        c.rs_b     = sw'(1 + $urandom % (nr - 1));
        c.quot_sel = sw'($urandom % nr);
        c.mod_sel  = sw'($urandom % nr);
        op_a       = (c.rs_a == c.rs_b) ? c.pre_b : c.pre_a;
        op_b       = c.pre_b;
        c.exp_quot = expected_quotient(op_a, op_b);
        c.exp_rem  = expected_remainder(op_a, op_b);
        return c;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(32'h93a5_a603));
        for (int i = 0; i < nr; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("busy", busy, 1'b0);
        check_bit("host_wr_ack", host_wr_ack, 1'b0);
        check_all_regs();
        for (int n = 0; n < num_cases; n++) begin
            run_case(case_table[n]);
        end
        for (int n = 0; n < num_random; n++) begin
            run_case(make_random_case());
        end
        $display("PASS: all tests");
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) #100;
        $display("Error: run did not finish within %0d cycles, divider in %s, grant %s",
                 timeout_cycles, i_div_regfile_top.i_int_div_regfile.state.name(),
                 i_div_regfile_top.i_reg_file.grant.name());
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== hdl/div_regfile_top.sv ====
// integer division subsystem: register file plus iterative divider
// the host starts a division with a one cycle div_req while busy is low,
// and completion is marked by busy falling; latency depends on write contention
`timescale 1ns/1ps

module div_regfile_top import div_pkg::*; #(
    parameter int data_width = default_data_width,
    parameter int num_regs   = default_num_regs,
    localparam int sel_width = $clog2(num_regs)
) (
    input  logic                  clk,
    input  logic                  rst,

    // division command
    input  logic                  div_req,
    input  logic [sel_width-1:0]  rs_a,          // dividend register
    input  logic [sel_width-1:0]  rs_b,          // divisor register
    input  logic [sel_width-1:0]  r_quot_sel,
    input  logic [sel_width-1:0]  r_mod_sel,
    output logic                  busy,

    // host access to the register file
    input  logic                  host_wr_req,
    input  logic [sel_width-1:0]  host_wr_sel,
    input  logic [data_width-1:0] host_wr_data,
    output logic                  host_wr_ack,
    input  logic [sel_width-1:0]  obs_sel,
    output logic [data_width-1:0] obs_data
);

    logic [data_width-1:0] rd_a;
    logic [data_width-1:0] rd_b;

    // divider write-back path
    logic                  div_wr_req;
    logic [sel_width-1:0]  div_wr_sel;
    logic [data_width-1:0] div_wr_data;
    logic                  div_wr_ack;

    reg_file #(
        .data_width (data_width),
        .num_regs   (num_regs)
    ) i_reg_file (
        .clk          (clk),
        .rst          (rst),
        .div_wr_req   (div_wr_req),
        .div_wr_sel   (div_wr_sel),
        .div_wr_data  (div_wr_data),
        .div_wr_ack   (div_wr_ack),
        .host_wr_req  (host_wr_req),
        .host_wr_sel  (host_wr_sel),
        .host_wr_data (host_wr_data),
        .host_wr_ack  (host_wr_ack),
        .rs_a         (rs_a),
        .rs_b         (rs_b),
        .obs_sel      (obs_sel),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .obs_data     (obs_data)
    );

    int_div_regfile #(
        .data_width (data_width),
        .num_regs   (num_regs)
    ) i_int_div_regfile (
        .clk        (clk),
        .rst        (rst),
        .req        (div_req),
        .busy       (busy),
        .r_quot_sel (r_quot_sel),
        .r_mod_sel  (r_mod_sel),
        .a          (rd_a),
        .b          (rd_b),
        .rf_wr_sel  (div_wr_sel),
        .rf_wr_data (div_wr_data),
        .rf_wr_req  (div_wr_req),
        .rf_wr_ack  (div_wr_ack)
    );

endmodule

// ==== hdl/int_div_regfile.sv ====
// iterative unsigned restoring divider, one quotient bit per clock
// operands are sampled when req is taken, results go back over a req/ack write port
// a zero destination select skips that write; division by zero gives all ones
// and a remainder equal to the dividend
// req must only be raised while busy is low
`timescale 1ns/1ps

module int_div_regfile import div_pkg::*; #(
    parameter int data_width = default_data_width,
    parameter int num_regs   = default_num_regs,
    localparam int sel_width = $clog2(num_regs)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    output logic                  busy,
    input  logic [sel_width-1:0]  r_quot_sel,    // 0 means no quotient write
    input  logic [sel_width-1:0]  r_mod_sel,     // 0 means no remainder write
    input  logic [data_width-1:0] a,             // dividend
    input  logic [data_width-1:0] b,             // divisor
    output logic [sel_width-1:0]  rf_wr_sel,
    output logic [data_width-1:0] rf_wr_data,
    output logic                  rf_wr_req,
    input  logic                  rf_wr_ack
);

    localparam int pos_width = (data_width > 1) ? $clog2(data_width) : 1;
    localparam logic [pos_width-1:0] last_pos = pos_width'(data_width - 1);

    div_state_e state, state_d;
    logic busy_d;
    logic wr_req_d;
    logic [pos_width-1:0] pos, pos_d;

    // operand and result registers of the division in flight
    logic [data_width-1:0] divisor, divisor_d;
    logic [data_width-1:0] quot, quot_d;
    logic [data_width-1:0] rem, rem_d;
    logic [sel_width-1:0]  quot_sel_q, quot_sel_d;
    logic [sel_width-1:0]  mod_sel_q, mod_sel_d;
    logic [sel_width-1:0]  wr_sel_d;
    logic [data_width-1:0] wr_data_d;

    // ~~~~~~~~~~~~~~~~~~~~
    // one restoring step at bit position pos
    logic [2*data_width-1:0] shifted;
    logic                    take;
    logic [data_width-1:0]   step_quot;
    logic [data_width-1:0]   step_rem;

    always_comb begin
        shifted   = {{data_width{1'b0}}, divisor} << pos;
        take      = shifted <= {{data_width{1'b0}}, rem};  // equal operands must subtract too
        step_rem  = take ? rem - shifted[data_width-1:0] : rem;
        step_quot = quot;
        step_quot[pos] = take;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // next state
    always_comb begin
        state_d    = state;
        busy_d     = busy;
        wr_req_d   = rf_wr_req;
        pos_d      = pos;
        divisor_d  = divisor;
        quot_d     = quot;
        rem_d      = rem;
        quot_sel_d = quot_sel_q;
        mod_sel_d  = mod_sel_q;
        wr_sel_d   = rf_wr_sel;
        wr_data_d  = rf_wr_data;

        case (state)
            idle: begin
                if (req) begin
                    state_d    = calc;
                    busy_d     = 1'b1;
                    pos_d      = last_pos;
                    divisor_d  = b;
                    quot_d     = '0;
                    rem_d      = a;
                    quot_sel_d = r_quot_sel;
                    mod_sel_d  = r_mod_sel;
                end
            end
            calc: begin
                quot_d = step_quot;
                rem_d  = step_rem;
                if (pos == '0) begin
                    // the last step result goes straight to the write outputs
                    if (quot_sel_q != '0) begin
                        state_d   = write_quot;
                        wr_req_d  = 1'b1;
                        wr_sel_d  = quot_sel_q;
                        wr_data_d = step_quot;
                    end else if (mod_sel_q != '0) begin
                        state_d   = write_mod;
                        wr_req_d  = 1'b1;
                        wr_sel_d  = mod_sel_q;
                        wr_data_d = step_rem;
                    end else begin
                        state_d = idle;                  // nothing to write back
                        busy_d  = 1'b0;
                    end
                end else begin
                    pos_d = pos - 1'b1;
                end
            end
            write_quot: begin
                if (rf_wr_ack) begin
                    if (mod_sel_q != '0) begin
                        state_d   = write_mod;          // req stays high with the new target
                        wr_sel_d  = mod_sel_q;
                        wr_data_d = rem;
                    end else begin
                        state_d  = idle;
                        busy_d   = 1'b0;
                        wr_req_d = 1'b0;
                    end
                end
            end
            write_mod: begin
                if (rf_wr_ack) begin
                    state_d  = idle;
                    busy_d   = 1'b0;
                    wr_req_d = 1'b0;
                end
            end
            default: begin
                state_d  = idle;
                busy_d   = 1'b0;
                wr_req_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            busy      <= 1'b0;
            rf_wr_req <= 1'b0;
            pos       <= '0;
        end else begin
            state     <= state_d;
            busy      <= busy_d;
            rf_wr_req <= wr_req_d;
            pos       <= pos_d;
        end
    end

    always_ff @(posedge clk) begin
        divisor    <= divisor_d;
        quot       <= quot_d;
        rem        <= rem_d;
        quot_sel_q <= quot_sel_d;
        mod_sel_q  <= mod_sel_d;
        rf_wr_sel  <= wr_sel_d;
        rf_wr_data <= wr_data_d;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // handshake rules toward the host and the register file
    a_no_req_when_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !req);

    a_no_write_to_zero: assert property (@(posedge clk) disable iff (rst)
        rf_wr_req |-> rf_wr_sel != '0);

    // a pending write keeps its target and data until the register file answers
    a_write_held: assert property (@(posedge clk) disable iff (rst)
        rf_wr_req && !rf_wr_ack |=> rf_wr_req && $stable(rf_wr_sel) && $stable(rf_wr_data));

endmodule

// ==== hdl/reg_file.sv ====
// register file with two operand read ports, one observation read port and
// a single write port shared by the divider and the host
// register 0 always reads zero; a write to it is acknowledged and dropped
// the divider has priority; every ack lasts one cycle after the write edge
`timescale 1ns/1ps

module reg_file import div_pkg::*; #(
    parameter int data_width = default_data_width,
    parameter int num_regs   = default_num_regs,
    localparam int sel_width = $clog2(num_regs)
) (
    input  logic                  clk,
    input  logic                  rst,

    // divider write port
    input  logic                  div_wr_req,
    input  logic [sel_width-1:0]  div_wr_sel,
    input  logic [data_width-1:0] div_wr_data,
    output logic                  div_wr_ack,

    // host write port
    input  logic                  host_wr_req,
    input  logic [sel_width-1:0]  host_wr_sel,
    input  logic [data_width-1:0] host_wr_data,
    output logic                  host_wr_ack,

    // combinational reads
    input  logic [sel_width-1:0]  rs_a,
    input  logic [sel_width-1:0]  rs_b,
    input  logic [sel_width-1:0]  obs_sel,
    output logic [data_width-1:0] rd_a,
    output logic [data_width-1:0] rd_b,
    output logic [data_width-1:0] obs_data
);

    logic [data_width-1:0] regs [num_regs];

    rf_grant_e grant;                 // writer whose ack is showing this cycle
    rf_grant_e grant_d;               // writer granted on the coming edge
    logic [sel_width-1:0]  wr_sel;
    logic [data_width-1:0] wr_data;
    logic                  wr_en;

    // ~~~~~~~~~~~~~~~~~~~~
    // write arbitration
    always_comb begin
        grant_d = grant_none;
        // while an ack is out its writer still shows req, so skip one cycle
        if (grant == grant_none) begin
            if (div_wr_req) begin
                grant_d = grant_div;
            end else if (host_wr_req) begin
                grant_d = grant_host;
            end
        end
    end

    assign wr_sel  = (grant_d == grant_div) ? div_wr_sel : host_wr_sel;
    assign wr_data = (grant_d == grant_div) ? div_wr_data : host_wr_data;
    assign wr_en   = (grant_d != grant_none) && (wr_sel != '0);  // register 0 stays zero

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= grant_none;
        end else begin
            grant <= grant_d;
        end
    end

    assign div_wr_ack  = (grant == grant_div);
    assign host_wr_ack = (grant == grant_host);

    // ~~~~~~~~~~~~~~~~~~~~
    // storage, cleared so that every register reads zero after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // reads see the value before a write on the same edge
    assign rd_a     = regs[rs_a];
    assign rd_b     = regs[rs_b];
    assign obs_data = regs[obs_sel];

    a_single_ack: assert property (@(posedge clk) disable iff (rst)
        !(div_wr_ack && host_wr_ack));

endmodule

// ==== hdl/div_pkg.sv ====
// shared defaults and enums for the integer divider subsystem
// data width and register count are top level parameters, the values here are defaults
package div_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // default sizes, overridden through the top level parameters
    localparam int default_data_width = 32;
    localparam int default_num_regs   = 32;

    // divider FSM, one division in flight at a time
    typedef enum logic [1:0] {
        idle,
        calc,
        write_quot,
        write_mod
    } div_state_e;

    // owner of the register file write port
    typedef enum logic [1:0] {
        grant_none,
        grant_div,
        grant_host
    } rf_grant_e;

endpackage
